// ==== hw/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // one enable bit per byte lane
    typedef logic [3:0] strb_t;

    // transaction id, echoed on r and b
    typedef logic [3:0] id_t;

    // beats in a burst minus one
    typedef logic [7:0] len_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'd0;
    // access outside the memory
    localparam resp_t RESP_SLVERR = 2'd2;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
    input  logic                clock,
    input  logic                reset,
    // fetch port
    input  mem_bus_pkg::addr_t  if_araddr,
    input  mem_bus_pkg::id_t    if_arid,
    input  mem_bus_pkg::len_t   if_arlen,
    input  logic                if_arvalid,
    output logic                if_arready,
    output mem_bus_pkg::data_t  if_rdata,
    output mem_bus_pkg::resp_t  if_rresp,
    output mem_bus_pkg::id_t    if_rid,
    output logic                if_rlast,
    output logic                if_rvalid,
    input  logic                if_rready,
    // load/store port
    input  mem_bus_pkg::addr_t  ls_araddr,
    input  mem_bus_pkg::id_t    ls_arid,
    input  mem_bus_pkg::len_t   ls_arlen,
    input  logic                ls_arvalid,
    output logic                ls_arready,
    output mem_bus_pkg::data_t  ls_rdata,
    output mem_bus_pkg::resp_t  ls_rresp,
    output mem_bus_pkg::id_t    ls_rid,
    output logic                ls_rlast,
    output logic                ls_rvalid,
    input  logic                ls_rready,
    input  mem_bus_pkg::addr_t  ls_awaddr,
    input  mem_bus_pkg::id_t    ls_awid,
    input  logic                ls_awvalid,
    output logic                ls_awready,
    input  mem_bus_pkg::data_t  ls_wdata,
    input  mem_bus_pkg::strb_t  ls_wstrb,
    input  logic                ls_wvalid,
    output logic                ls_wready,
    output mem_bus_pkg::resp_t  ls_bresp,
    output mem_bus_pkg::id_t    ls_bid,
    output logic                ls_bvalid,
    input  logic                ls_bready,
    // shared bus toward the memory
    output logic                arvalid,
    output mem_bus_pkg::addr_t  araddr,
    output mem_bus_pkg::id_t    arid,
    output mem_bus_pkg::len_t   arlen,
    input  logic                arready,
    input  logic                rvalid,
    input  mem_bus_pkg::data_t  rdata,
    input  mem_bus_pkg::resp_t  rresp,
    input  mem_bus_pkg::id_t    rid,
    input  logic                rlast,
    output logic                rready,
    output logic                awvalid,
    output mem_bus_pkg::addr_t  awaddr,
    output mem_bus_pkg::id_t    awid,
    input  logic                awready,
    output logic                wvalid,
    output mem_bus_pkg::data_t  wdata,
    output mem_bus_pkg::strb_t  wstrb,
    input  logic                wready,
    input  logic                bvalid,
    input  mem_bus_pkg::resp_t  bresp,
    input  mem_bus_pkg::id_t    bid,
    output logic                bready
);

    mem_bus_pkg::arb_state_t state;
    logic grant_ls;
    logic txn_done;

    // last read beat or write response accepted
    assign txn_done = (rvalid && rready && rlast) || (bvalid && bready);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= mem_bus_pkg::ARB_IDLE;
            grant_ls <= 1'b0;
        end else begin
            case (state)
                mem_bus_pkg::ARB_IDLE: begin
                    // fetch has priority
                    if (if_arvalid) begin
                        state    <= mem_bus_pkg::ARB_BUSY;
                        grant_ls <= 1'b0;
                    end else if (ls_arvalid || ls_awvalid) begin
                        state    <= mem_bus_pkg::ARB_BUSY;
                        grant_ls <= 1'b1;
                    end
                end
                mem_bus_pkg::ARB_BUSY: begin
                    if (txn_done) begin
                        state <= mem_bus_pkg::ARB_IDLE;
                    end
                end
                default: state <= mem_bus_pkg::ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        // nothing moves unless granted
        arvalid = 1'b0;
        araddr  = '0;
        arid    = '0;
        arlen   = '0;
        rready  = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        awid    = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;

        if_arready = 1'b0;
        if_rvalid  = 1'b0;
        if_rdata   = '0;
        if_rresp   = '0;
        if_rid     = '0;
        if_rlast   = 1'b0;

        ls_arready = 1'b0;
        ls_rvalid  = 1'b0;
        ls_rdata   = '0;
        ls_rresp   = '0;
        ls_rid     = '0;
        ls_rlast   = 1'b0;
        ls_awready = 1'b0;
        ls_wready  = 1'b0;
        ls_bvalid  = 1'b0;
        ls_bresp   = '0;
        ls_bid     = '0;

        if (state == mem_bus_pkg::ARB_BUSY) begin
            if (grant_ls) begin
                arvalid    = ls_arvalid;
                araddr     = ls_araddr;
                arid       = ls_arid;
                arlen      = ls_arlen;
                ls_arready = arready;
                rready     = ls_rready;
                ls_rvalid  = rvalid;
                ls_rdata   = rdata;
                ls_rresp   = rresp;
                ls_rid     = rid;
                ls_rlast   = rlast;
                awvalid    = ls_awvalid;
                awaddr     = ls_awaddr;
                awid       = ls_awid;
                ls_awready = awready;
                wvalid     = ls_wvalid;
                wdata      = ls_wdata;
                wstrb      = ls_wstrb;
                ls_wready  = wready;
                bready     = ls_bready;
                ls_bvalid  = bvalid;
                ls_bresp   = bresp;
                ls_bid     = bid;
            end else begin
                // read channels only, fetch never writes
                arvalid    = if_arvalid;
                araddr     = if_araddr;
                arid       = if_arid;
                arlen      = if_arlen;
                if_arready = arready;
                rready     = if_rready;
                if_rvalid  = rvalid;
                if_rdata   = rdata;
                if_rresp   = rresp;
                if_rid     = rid;
                if_rlast   = rlast;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/sram_slave.sv ====
`default_nettype none

module sram_slave #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                clock,
    input  logic                reset,
    // read address
    input  logic                arvalid,
    input  mem_bus_pkg::addr_t  araddr,
    input  mem_bus_pkg::id_t    arid,
    input  mem_bus_pkg::len_t   arlen,
    output logic                arready,
    // read data
    output logic                rvalid,
    output mem_bus_pkg::data_t  rdata,
    output mem_bus_pkg::resp_t  rresp,
    output mem_bus_pkg::id_t    rid,
    output logic                rlast,
    input  logic                rready,
    // write address and data
    input  logic                awvalid,
    input  mem_bus_pkg::addr_t  awaddr,
    input  mem_bus_pkg::id_t    awid,
    output logic                awready,
    input  logic                wvalid,
    input  mem_bus_pkg::data_t  wdata,
    input  mem_bus_pkg::strb_t  wstrb,
    output logic                wready,
    // write response
    output logic                bvalid,
    output mem_bus_pkg::resp_t  bresp,
    output mem_bus_pkg::id_t    bid,
    input  logic                bready
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // word index of a byte address, wide enough to see out of range
    typedef logic [29:0] word_idx_t;
    localparam word_idx_t DEPTH_LIMIT = word_idx_t'(DEPTH_WORDS);

    mem_bus_pkg::data_t mem [DEPTH_WORDS];

    logic               rd_active;
    word_idx_t          rd_index;
    mem_bus_pkg::id_t   rd_id;
    mem_bus_pkg::len_t  rd_left;
    logic               rd_in_range;

    word_idx_t          wr_index;
    logic               wr_in_range;
    logic               wr_fire;

    // read engine, one burst at a time
    assign arready     = !rd_active;
    assign rvalid      = rd_active;
    assign rid         = rd_id;
    assign rlast       = (rd_left == '0);
    assign rd_in_range = (rd_index < DEPTH_LIMIT);
    assign rresp       = rd_in_range ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
    assign rdata       = rd_in_range ? mem[rd_index[IDX_W-1:0]] : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_active <= 1'b0;
        end else if (arvalid && arready) begin
            rd_active <= 1'b1;
        end else if (rvalid && rready && rlast) begin
            rd_active <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rd_index <= araddr[31:2];
            rd_id    <= arid;
            rd_left  <= arlen;
        end else if (rvalid && rready && !rlast) begin
            // next word of the burst
            rd_index <= rd_index + 1'b1;
            rd_left  <= rd_left - 1'b1;
        end
    end

    // aw and w are taken together, only with no response pending
    assign wr_index    = awaddr[31:2];
    assign wr_in_range = (wr_index < DEPTH_LIMIT);
    assign awready     = awvalid && wvalid && !bvalid;
    assign wready      = awready;
    assign wr_fire     = awvalid && awready;

    always_ff @(posedge clock) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            bid   <= awid;
            bresp <= wr_in_range ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
        end
    end

    // byte lanes per strobe, out of range writes dropped
    always_ff @(posedge clock) begin
        if (wr_fire && wr_in_range) begin
            for (int i = 0; i < $bits(mem_bus_pkg::strb_t); i++) begin
                if (wstrb[i]) begin
                    mem[wr_index[IDX_W-1:0]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                clock,
    input  logic                reset,
    // fetch port
    input  mem_bus_pkg::addr_t  if_araddr,
    input  mem_bus_pkg::id_t    if_arid,
    input  mem_bus_pkg::len_t   if_arlen,
    input  logic                if_arvalid,
    output logic                if_arready,
    output mem_bus_pkg::data_t  if_rdata,
    output mem_bus_pkg::resp_t  if_rresp,
    output mem_bus_pkg::id_t    if_rid,
    output logic                if_rlast,
    output logic                if_rvalid,
    input  logic                if_rready,
    // load/store port
    input  mem_bus_pkg::addr_t  ls_araddr,
    input  mem_bus_pkg::id_t    ls_arid,
    input  mem_bus_pkg::len_t   ls_arlen,
    input  logic                ls_arvalid,
    output logic                ls_arready,
    output mem_bus_pkg::data_t  ls_rdata,
    output mem_bus_pkg::resp_t  ls_rresp,
    output mem_bus_pkg::id_t    ls_rid,
    output logic                ls_rlast,
    output logic                ls_rvalid,
    input  logic                ls_rready,
    input  mem_bus_pkg::addr_t  ls_awaddr,
    input  mem_bus_pkg::id_t    ls_awid,
    input  logic                ls_awvalid,
    output logic                ls_awready,
    input  mem_bus_pkg::data_t  ls_wdata,
    input  mem_bus_pkg::strb_t  ls_wstrb,
    input  logic                ls_wvalid,
    output logic                ls_wready,
    output mem_bus_pkg::resp_t  ls_bresp,
    output mem_bus_pkg::id_t    ls_bid,
    output logic                ls_bvalid,
    input  logic                ls_bready
);

    // bus between arbiter and memory
    logic                arvalid, arready;
    mem_bus_pkg::addr_t  araddr;
    mem_bus_pkg::id_t    arid;
    mem_bus_pkg::len_t   arlen;
    logic                rvalid, rready, rlast;
    mem_bus_pkg::data_t  rdata;
    mem_bus_pkg::resp_t  rresp;
    mem_bus_pkg::id_t    rid;
    logic                awvalid, awready;
    mem_bus_pkg::addr_t  awaddr;
    mem_bus_pkg::id_t    awid;
    logic                wvalid, wready;
    mem_bus_pkg::data_t  wdata;
    mem_bus_pkg::strb_t  wstrb;
    logic                bvalid, bready;
    mem_bus_pkg::resp_t  bresp;
    mem_bus_pkg::id_t    bid;

    // port names match the bus names on both sides
    bus_arbiter i_bus_arbiter (
        .*
    );

    sram_slave #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) i_sram_slave (
        .*
    );

endmodule

`default_nettype wire

// ==== verification/bus_arbiter_assert.sv ====
`default_nettype none

module bus_arbiter_assert (
    input logic                    clock,
    input logic                    reset,
    input mem_bus_pkg::arb_state_t state,
    input logic                    grant_ls,
    input logic                    if_arready, if_rvalid,
    input logic                    ls_arready, ls_rvalid, ls_awready, ls_wready, ls_bvalid,
    input logic                    arvalid, awvalid, wvalid
);

    int failures = 0;

    logic fetch_active;
    logic ls_active;

    assign fetch_active = if_arready || if_rvalid;
    assign ls_active    = ls_arready || ls_rvalid || ls_awready || ls_wready || ls_bvalid;

    // only the granted master ever sees a ready or a response
    one_master: assert property (@(posedge clock) disable iff (reset)
        !(fetch_active && ls_active))
        else begin
            $error("fetch and load/store ports active in the same cycle");
            failures++;
        end

    // bus stays quiet while idle
    idle_quiet: assert property (@(posedge clock) disable iff (reset)
        (state == mem_bus_pkg::ARB_IDLE) |-> !(arvalid || awvalid || wvalid))
        else begin
            $error("bus valid raised while the arbiter is idle");
            failures++;
        end

    grant_stable: assert property (@(posedge clock) disable iff (reset)
        (state == mem_bus_pkg::ARB_BUSY && $past(state) == mem_bus_pkg::ARB_BUSY)
            |-> $stable(grant_ls))
        else begin
            $error("grant changed during a transaction");
            failures++;
        end

endmodule

`default_nettype wire

// ==== verification/mem_checker.sv ====
`default_nettype none

module mem_checker #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic               clock,
    input  logic               reset,
    input  mem_bus_pkg::addr_t if_araddr, ls_araddr, ls_awaddr,
    input  mem_bus_pkg::id_t   if_arid, if_rid, ls_arid, ls_rid, ls_awid, ls_bid,
    input  mem_bus_pkg::len_t  if_arlen, ls_arlen,
    input  mem_bus_pkg::data_t if_rdata, ls_rdata, ls_wdata,
    input  mem_bus_pkg::resp_t if_rresp, ls_rresp, ls_bresp,
    input  mem_bus_pkg::strb_t ls_wstrb,
    input  logic               if_arvalid, if_arready, if_rvalid, if_rready, if_rlast,
    input  logic               ls_arvalid, ls_arready, ls_rvalid, ls_rready, ls_rlast,
    input  logic               ls_awvalid, ls_awready, ls_wvalid, ls_wready,
    input  logic               ls_bvalid, ls_bready,
    output int                 errors,
    output logic               idle
);

    mem_bus_pkg::data_t shadow [DEPTH_WORDS];

    // read request as {word index, id, len}
    logic [41:0] if_reqs[$];
    logic [41:0] ls_reqs[$];
    // expected write response as {id, resp}
    logic [5:0]  b_expected[$];
    int          if_beat;
    int          ls_beat;

    // old word with the enabled byte lanes replaced
    function automatic mem_bus_pkg::data_t merge_write(input mem_bus_pkg::data_t old_word,
            input mem_bus_pkg::data_t new_word, input mem_bus_pkg::strb_t strb);
        mem_bus_pkg::data_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    // expected {resp, data} for one word index
    function automatic logic [33:0] exp_read(input logic [29:0] index);
        if (index < DEPTH_WORDS) begin
            return {mem_bus_pkg::RESP_OKAY, shadow[int'(index)]};
        end
        return {mem_bus_pkg::RESP_SLVERR, 32'h0};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_beat(input string port, input logic [41:0] req, input int beat,
            input mem_bus_pkg::data_t rdata, input mem_bus_pkg::resp_t rresp,
            input mem_bus_pkg::id_t rid, input logic rlast);
        logic [33:0] expected;
        expected = exp_read(req[41:12] + 30'(beat));
        compare_value({port, "_rdata"}, rdata, expected[31:0]);
        compare_value({port, "_rresp"}, 32'(rresp), 32'(expected[33:32]));
        compare_value({port, "_rid"}, 32'(rid), 32'(req[11:8]));
        compare_value({port, "_rlast"}, 32'(rlast), 32'(beat == int'(req[7:0])));
    endtask

    always @(posedge clock) begin
        if (reset) begin
            errors = 0;
            if_beat = 0;
            ls_beat = 0;
            if_reqs.delete();
            ls_reqs.delete();
            b_expected.delete();
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                shadow[i] = '0;
            end
        end else begin
            if (if_rvalid && if_rready) begin
                if (if_reqs.size() == 0) begin
                    $display("error at %0t: read beat on fetch port with no request", $time);
                    errors++;
                end else begin
                    check_beat("if", if_reqs[0], if_beat, if_rdata, if_rresp, if_rid, if_rlast);
                    if (if_beat == int'(if_reqs[0][7:0])) begin
                        void'(if_reqs.pop_front());
                        if_beat = 0;
                    end else begin
                        if_beat++;
                    end
                end
            end
            if (ls_rvalid && ls_rready) begin
                if (ls_reqs.size() == 0) begin
                    $display("error at %0t: read beat on load/store port with no request", $time);
                    errors++;
                end else begin
                    check_beat("ls", ls_reqs[0], ls_beat, ls_rdata, ls_rresp, ls_rid, ls_rlast);
                    if (ls_beat == int'(ls_reqs[0][7:0])) begin
                        void'(ls_reqs.pop_front());
                        ls_beat = 0;
                    end else begin
                        ls_beat++;
                    end
                end
            end
            if (ls_bvalid && ls_bready) begin
                if (b_expected.size() == 0) begin
                    $display("error at %0t: write response with no write outstanding", $time);
                    errors++;
                end else begin
                    compare_value("ls_bid", 32'(ls_bid), 32'(b_expected[0][5:2]));
                    compare_value("ls_bresp", 32'(ls_bresp), 32'(b_expected[0][1:0]));
                    void'(b_expected.pop_front());
                end
            end
            // requests as they are handed over
            if (if_arvalid && if_arready) begin
                if_reqs.push_back({if_araddr[31:2], if_arid, if_arlen});
            end
            if (ls_arvalid && ls_arready) begin
                ls_reqs.push_back({ls_araddr[31:2], ls_arid, ls_arlen});
            end
            if (ls_awvalid && ls_awready && ls_wvalid && ls_wready) begin
                if (ls_awaddr[31:2] < DEPTH_WORDS) begin
                    shadow[int'(ls_awaddr[31:2])] =
                        merge_write(shadow[int'(ls_awaddr[31:2])], ls_wdata, ls_wstrb);
                    b_expected.push_back({ls_awid, mem_bus_pkg::RESP_OKAY});
                end else begin
                    b_expected.push_back({ls_awid, mem_bus_pkg::RESP_SLVERR});
                end
            end
        end
        idle = (if_reqs.size() == 0) && (ls_reqs.size() == 0) && (b_expected.size() == 0);
    end

endmodule

`default_nettype wire

// ==== verification/mem_subsystem_tb.sv ====
`default_nettype none

module mem_subsystem_tb;

    localparam int DEPTH_WORDS  = 256;
    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 16;
    localparam int N_STROBE     = 24;
    localparam int N_BURST      = 16;
    localparam int N_DUAL       = 4;
    localparam int N_RANGE      = 6;
    localparam int N_MIX        = 48;
    // preload, write plus readback, bursts, pairs, range triples, straddle, mix
    localparam int N_TXN = DEPTH_WORDS + 2 * N_STROBE + N_BURST + 2 * N_DUAL
                         + 3 * N_RANGE + 1 + N_MIX;
    localparam int TIMEOUT_CYCLES = 40 * N_TXN + RESET_CYCLES;

    logic               clock;
    logic               reset;
    mem_bus_pkg::addr_t if_araddr;
    mem_bus_pkg::id_t   if_arid, if_rid;
    mem_bus_pkg::len_t  if_arlen;
    mem_bus_pkg::data_t if_rdata;
    mem_bus_pkg::resp_t if_rresp;
    logic               if_arvalid, if_arready, if_rlast, if_rvalid, if_rready;
    mem_bus_pkg::addr_t ls_araddr, ls_awaddr;
    mem_bus_pkg::id_t   ls_arid, ls_rid, ls_awid, ls_bid;
    mem_bus_pkg::len_t  ls_arlen;
    mem_bus_pkg::data_t ls_rdata, ls_wdata;
    mem_bus_pkg::resp_t ls_rresp, ls_bresp;
    mem_bus_pkg::strb_t ls_wstrb;
    logic               ls_arvalid, ls_arready, ls_rlast, ls_rvalid, ls_rready;
    logic               ls_awvalid, ls_awready, ls_wvalid, ls_wready, ls_bvalid, ls_bready;

    int          checker_errors;
    logic        checker_idle;
    int          seq_errors = 0;
    logic [31:0] rng_state = 32'hb10c_65dc;
    time         fetch_end_time;
    time         ls_grant_time;

    mem_subsystem #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) i_mem_subsystem (
        .*
    );

    mem_checker #(
        .DEPTH_WORDS(DEPTH_WORDS)
    ) i_mem_checker (
        .*,
        .errors(checker_errors),
        .idle(checker_idle)
    );

    bind bus_arbiter bus_arbiter_assert i_bus_arbiter_assert (
        .clock(clock),
        .reset(reset),
        .state(state),
        .grant_ls(grant_ls),
        .if_arready(if_arready),
        .if_rvalid(if_rvalid),
        .ls_arready(ls_arready),
        .ls_rvalid(ls_rvalid),
        .ls_awready(ls_awready),
        .ls_wready(ls_wready),
        .ls_bvalid(ls_bvalid),
        .arvalid(arvalid),
        .awvalid(awvalid),
        .wvalid(wvalid)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic clear_inputs();
        if_araddr  = '0;
        if_arid    = '0;
        if_arlen   = '0;
        if_arvalid = 1'b0;
        if_rready  = 1'b0;
        ls_araddr  = '0;
        ls_arid    = '0;
        ls_arlen   = '0;
        ls_arvalid = 1'b0;
        ls_rready  = 1'b0;
        ls_awaddr  = '0;
        ls_awid    = '0;
        ls_awvalid = 1'b0;
        ls_wdata   = '0;
        ls_wstrb   = '0;
        ls_wvalid  = 1'b0;
        ls_bready  = 1'b0;
    endtask

    // burst on either port with random rready gaps when stall is set
    task automatic read_burst(input bit on_ls, input int unsigned word,
            input mem_bus_pkg::id_t id, input mem_bus_pkg::len_t len, input bit stall);
        logic ready;
        @(negedge clock);
        if (on_ls) begin
            ls_araddr  = mem_bus_pkg::addr_t'(word << 2);
            ls_arid    = id;
            ls_arlen   = len;
            ls_arvalid = 1'b1;
        end else begin
            if_araddr  = mem_bus_pkg::addr_t'(word << 2);
            if_arid    = id;
            if_arlen   = len;
            if_arvalid = 1'b1;
        end
        forever begin
            @(posedge clock);
            if (on_ls ? ls_arready : if_arready) break;
        end
        if (on_ls) ls_grant_time = $time;
        @(negedge clock);
        ls_arvalid = on_ls ? 1'b0 : ls_arvalid;
        if_arvalid = on_ls ? if_arvalid : 1'b0;
        forever begin
            ready = !stall || (next_random() % 4 != 0);
            if (on_ls) ls_rready = ready;
            else if_rready = ready;
            @(posedge clock);
            // the DUT marks the final beat with rlast
            if (ready && (on_ls ? ls_rvalid && ls_rlast : if_rvalid && if_rlast)) break;
            @(negedge clock);
        end
        if (!on_ls) fetch_end_time = $time;
        @(negedge clock);
        if (on_ls) ls_rready = 1'b0;
        else if_rready = 1'b0;
    endtask

    task automatic write_word(input int unsigned word, input mem_bus_pkg::id_t id,
            input mem_bus_pkg::data_t data, input mem_bus_pkg::strb_t strb, input bit stall);
        logic ready;
        @(negedge clock);
        ls_awaddr  = mem_bus_pkg::addr_t'(word << 2);
        ls_awid    = id;
        ls_wdata   = data;
        ls_wstrb   = strb;
        ls_awvalid = 1'b1;
        ls_wvalid  = 1'b1;
        forever begin
            @(posedge clock);
            if (ls_awready) break;
        end
        @(negedge clock);
        ls_awvalid = 1'b0;
        ls_wvalid  = 1'b0;
        forever begin
            ready = !stall || (next_random() % 4 != 0);
            ls_bready = ready;
            @(posedge clock);
            if (ready && ls_bvalid) break;
            @(negedge clock);
        end
        @(negedge clock);
        ls_bready = 1'b0;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        int unsigned word;
        int          assert_failures;
        int          total;
        clear_inputs();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // full-strobe fill so DUT and shadow agree
        for (int w = 0; w < DEPTH_WORDS; w++) begin
            write_word(w, 4'd0, next_random(), 4'hf, 1'b0);
        end

        // strobed writes to a few words and a readback of each
        for (int n = 0; n < N_STROBE; n++) begin
            rnd = next_random();
            write_word(rnd[2:0], rnd[7:4], next_random(), rnd[11:8], 1'b0);
            read_burst(1'b1, rnd[2:0], rnd[15:12], 8'd0, 1'b0);
        end

        for (int n = 0; n < N_BURST; n++) begin
            rnd = next_random();
            word = rnd[31:8] % (DEPTH_WORDS - 8);
            read_burst(1'b0, word, rnd[3:0], {5'd0, rnd[6:4]}, 1'b0);
        end

        // both masters request in the same cycle and fetch must finish first
        for (int n = 0; n < N_DUAL; n++) begin
            rnd = next_random();
            word = rnd[31:8] % (DEPTH_WORDS - 8);
            fork
                read_burst(1'b0, word, rnd[3:0], {5'd0, rnd[6:4]}, 1'b0);
                read_burst(1'b1, rnd[7:0], rnd[11:8], 8'd0, 1'b0);
            join
            if (ls_grant_time <= fetch_end_time) begin
                $display("error at %0t: load/store read accepted before fetch burst ended",
                    $time);
                seq_errors++;
            end
        end

        // beyond the depth and then the aliased in-range word
        for (int n = 0; n < N_RANGE; n++) begin
            rnd = next_random();
            word = DEPTH_WORDS + rnd[5:0];
            write_word(word, rnd[9:6], next_random(), 4'hf, 1'b0);
            read_burst(1'b1, word, rnd[13:10], 8'd0, 1'b0);
            read_burst(1'b0, word % DEPTH_WORDS, rnd[17:14], 8'd0, 1'b0);
        end
        read_burst(1'b0, DEPTH_WORDS - 2, 4'd9, 8'd3, 1'b0);

        // random mix with ready stalls
        for (int n = 0; n < N_MIX; n++) begin
            rnd = next_random();
            word = rnd[31:8] % (DEPTH_WORDS - 8);
            case (rnd[1:0] % 3)
                0: read_burst(1'b0, word, rnd[5:2], {5'd0, rnd[8:6]}, 1'b1);
                1: read_burst(1'b1, word, rnd[5:2], {6'd0, rnd[7:6]}, 1'b1);
                default: write_word(word, rnd[5:2], next_random(), rnd[11:8], 1'b1);
            endcase
        end

        repeat (4) @(posedge clock);
        if (!checker_idle) begin
            $display("error: requests left without a complete response");
            seq_errors++;
        end
        assert_failures = i_mem_subsystem.i_bus_arbiter.i_bus_arbiter_assert.failures;
        total = checker_errors + seq_errors + assert_failures;
        $display("errors: checker %0d, sequence %0d, assertions %0d",
            checker_errors, seq_errors, assert_failures);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/mem_bus_pkg.sv
hw/bus_arbiter.sv
hw/sram_slave.sv
hw/mem_subsystem.sv
verification/bus_arbiter_assert.sv
verification/mem_checker.sv
verification/mem_subsystem_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mem_subsystem_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log
SIM_ARGS = +verilator+error+limit+100
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: build run clean

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: build
	./$(BUILD)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
